// ==== Makefile ====
# Verilator build and run of the TCB subsystem testbench

SOURCES := $(filter-out +%,$(shell cat filelist.f)) testbench/tcb_tb_table.svh

.PHONY: all run clean

all: run

# rebuilt only when the file list or a source changes
obj_dir/Vtcb_subsystem_tb: filelist.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module tcb_subsystem_tb -f filelist.f

# pass only when the pass message shows up in the output
run: obj_dir/Vtcb_subsystem_tb
	@out="$$(./obj_dir/Vtcb_subsystem_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
rtl/tcb_bus_pkg.sv
rtl/tcb_map_pkg.sv
rtl/tcb_register_backpressure.sv
rtl/tcb_decoder.sv
rtl/tcb_memory.sv
rtl/tcb_status_regs.sv
rtl/tcb_subsystem.sv
+incdir+testbench
testbench/tcb_subsystem_tb.sv

// ==== rtl/tcb_bus_pkg.sv ====
/*
  TCB bus package
  address, data, byte enable and status field types,
  plus the byte-lane write merge used by every subordinate
*/

`default_nettype none

package tcb_bus_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // byte address
  localparam int unsigned adr_width = 16;
  // data word
  localparam int unsigned dat_width = 32;
  // one enable per data byte
  localparam int unsigned byt_width = dat_width / 8;

  ////////////////////////////////////////////////////////////
  // field types
  ////////////////////////////////////////////////////////////

  typedef logic [adr_width-1:0] adr_t;
  typedef logic [dat_width-1:0] dat_t;
  typedef logic [byt_width-1:0] byt_t;

  // response status, error only for unmapped addresses
  typedef logic sts_t;
  localparam sts_t sts_ok  = 1'b0;
  localparam sts_t sts_err = 1'b1;

  // new word from old contents and write data, only enabled lanes change
  function automatic dat_t byte_merge(dat_t old, dat_t wdt, byt_t byt);
    dat_t res;
    res = old;
    for (int unsigned i = 0; i < byt_width; i++) begin
      if (byt[i]) res[8*i +: 8] = wdt[8*i +: 8];
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/tcb_decoder.sv ====
/*
  TCB address decoder
  routes requests to memory or register bank, selects ready,
  steers responses back and answers unmapped addresses with an error
*/

`default_nettype none
`timescale 1ns/100ps

module tcb_decoder #(
  parameter int unsigned mem_words = 256
) (
  input  wire                logic sub,
  input  wire                logic reset,
  // upstream request and response
  input  wire                logic vld,
  input  wire                logic wen,
  input  tcb_bus_pkg::adr_t  adr,
  input  tcb_bus_pkg::byt_t  byt,
  input  tcb_bus_pkg::dat_t  wdt,
  output logic               rdy,
  output logic               rsp_vld,
  output tcb_bus_pkg::dat_t  rdt,
  output tcb_bus_pkg::sts_t  sts,
  // memory
  output logic               mem_vld,
  output logic               mem_wen,
  output tcb_bus_pkg::adr_t  mem_adr,
  output tcb_bus_pkg::byt_t  mem_byt,
  output tcb_bus_pkg::dat_t  mem_wdt,
  input  wire                logic mem_rdy,
  input  wire                logic mem_rsp_vld,
  input  tcb_bus_pkg::dat_t  mem_rdt,
  // register bank
  output logic               regs_vld,
  output logic               regs_wen,
  output tcb_bus_pkg::adr_t  regs_adr,
  output tcb_bus_pkg::byt_t  regs_byt,
  output tcb_bus_pkg::dat_t  regs_wdt,
  input  wire                logic regs_rdy,
  input  wire                logic regs_rsp_vld,
  input  tcb_bus_pkg::dat_t  regs_rdt
);

  // window sizes in bytes, memory bounded by its depth
  localparam int unsigned mem_win  = tcb_map_pkg::mem_last - tcb_map_pkg::mem_base + 1;
  localparam int unsigned mem_span = (mem_words * 4 < mem_win) ? mem_words * 4 : mem_win;
  localparam int unsigned regs_win = tcb_map_pkg::regs_last - tcb_map_pkg::regs_base + 1;

  ////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////

  tcb_bus_pkg::adr_t    mem_ofs;
  tcb_bus_pkg::adr_t    regs_ofs;
  tcb_map_pkg::region_t region;

  // offsets wrap below the base, so one compare per window is enough
  assign mem_ofs  = adr - tcb_map_pkg::mem_base;
  assign regs_ofs = adr - tcb_map_pkg::regs_base;

  always_comb begin
    if (32'(mem_ofs) < mem_span)       region = tcb_map_pkg::region_mem;
    else if (32'(regs_ofs) < regs_win) region = tcb_map_pkg::region_regs;
    else                               region = tcb_map_pkg::region_none;
  end

  // valid only toward the selected subordinate, payload shared
  assign mem_vld  = vld && (region == tcb_map_pkg::region_mem);
  assign mem_wen  = wen;
  assign mem_adr  = adr;
  assign mem_byt  = byt;
  assign mem_wdt  = wdt;
  assign regs_vld = vld && (region == tcb_map_pkg::region_regs);
  assign regs_wen = wen;
  assign regs_adr = adr;
  assign regs_byt = byt;
  assign regs_wdt = wdt;

  // unmapped requests are taken at once
  always_comb begin
    case (region)
      tcb_map_pkg::region_mem:  rdy = mem_rdy;
      tcb_map_pkg::region_regs: rdy = regs_rdy;
      default:                  rdy = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // response steering
  ////////////////////////////////////////////////////////////

  tcb_map_pkg::region_t rsp_region;
  logic                 err_vld;

  // region of the last transfer, error pulse for unmapped ones
  always_ff @(posedge sub) begin
    if (reset) begin
      rsp_region <= tcb_map_pkg::region_none;
      err_vld    <= 1'b0;
    end else begin
      if (vld && rdy) rsp_region <= region;
      err_vld <= vld && rdy && (region == tcb_map_pkg::region_none);
    end
  end

  always_comb begin
    case (rsp_region)
      tcb_map_pkg::region_mem: begin
        rsp_vld = mem_rsp_vld;
        rdt     = mem_rdt;
        sts     = tcb_bus_pkg::sts_ok;
      end
      tcb_map_pkg::region_regs: begin
        rsp_vld = regs_rsp_vld;
        rdt     = regs_rdt;
        sts     = tcb_bus_pkg::sts_ok;
      end
      default: begin
        rsp_vld = err_vld;
        rdt     = '0;
        sts     = tcb_bus_pkg::sts_err;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/tcb_map_pkg.sv ====
/*
  TCB subsystem address map package
  decode regions, window limits, register offsets and identity word
*/

`default_nettype none

package tcb_map_pkg;

  // decode result of one request address
  typedef enum logic [1:0] {
    region_none = 2'd0,
    region_mem  = 2'd1,
    region_regs = 2'd2
  } region_t;

  // memory window, further bounded by the memory depth
  localparam tcb_bus_pkg::adr_t mem_base  = 16'h0000;
  localparam tcb_bus_pkg::adr_t mem_last  = 16'h0FFF;

  // register window
  localparam tcb_bus_pkg::adr_t regs_base = 16'h1000;
  localparam tcb_bus_pkg::adr_t regs_last = 16'h100F;

  // register offsets inside the register window
  typedef logic [3:0] ofs_t;
  localparam ofs_t reg_id_ofs      = 4'h0;
  localparam ofs_t reg_scratch_ofs = 4'h4;
  localparam ofs_t reg_wait_ofs    = 4'h8;

  // identity word, read only
  localparam tcb_bus_pkg::dat_t id_value = 32'h7CB0_0001;

  // memory wait-state count
  typedef logic [3:0] wait_t;

endpackage

`default_nettype wire

// ==== rtl/tcb_memory.sv ====
/*
  TCB word memory
  byte-enabled writes, registered read data, wait-state counter
*/

`default_nettype none
`timescale 1ns/100ps

module tcb_memory #(
  parameter int unsigned mem_words = 256
) (
  input  wire                logic sub,
  input  wire                logic reset,
  input  wire                logic vld,
  input  wire                logic wen,
  input  tcb_bus_pkg::adr_t  adr,
  input  tcb_bus_pkg::byt_t  byt,
  input  tcb_bus_pkg::dat_t  wdt,
  input  tcb_map_pkg::wait_t wait_cycles,
  output logic               rdy,
  output logic               rsp_vld,
  output tcb_bus_pkg::dat_t  rdt
);

  // word index width, at least one bit
  localparam int unsigned idx_width = (mem_words > 1) ? $clog2(mem_words) : 1;

  ////////////////////////////////////////////////////////////
  // wait states
  ////////////////////////////////////////////////////////////

  tcb_map_pkg::wait_t cnt;

  // ready once enough cycles of valid have passed
  // compare with >= in case the setting drops mid request
  assign rdy = (cnt >= wait_cycles);

  always_ff @(posedge sub) begin
    if (reset) begin
      cnt <= '0;
    end else if (vld && rdy) begin
      cnt <= '0;
    end else if (vld) begin
      cnt <= cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  tcb_bus_pkg::dat_t        mem [mem_words];
  logic [idx_width-1:0]     idx;

  // byte address to word index
  assign idx = adr[idx_width+1:2];

  // write merges enabled lanes, read returns the word, write returns zero
  always_ff @(posedge sub) begin
    if (vld && rdy) begin
      if (wen) begin
        mem[idx] <= tcb_bus_pkg::byte_merge(mem[idx], wdt, byt);
        rdt      <= '0;
      end else begin
        rdt      <= mem[idx];
      end
    end
  end

  // response strobe one cycle after the transfer
  always_ff @(posedge sub) begin
    if (reset) rsp_vld <= 1'b0;
    else       rsp_vld <= vld && rdy;
  end

endmodule

`default_nettype wire

// ==== rtl/tcb_register_backpressure.sv ====
/*
  TCB register slice on the ready path
  registers ready toward the manager, holds one stalled request
*/

`default_nettype none
`timescale 1ns/100ps

module tcb_register_backpressure (
  input  wire                logic sub,
  input  wire                logic reset,
  // manager side request (this module is its subordinate)
  input  wire                logic sub_vld,
  input  wire                logic sub_wen,
  input  tcb_bus_pkg::adr_t  sub_adr,
  input  tcb_bus_pkg::byt_t  sub_byt,
  input  tcb_bus_pkg::dat_t  sub_wdt,
  output logic               sub_rdy,
  // manager side response
  output logic               sub_rsp_vld,
  output tcb_bus_pkg::dat_t  sub_rdt,
  output tcb_bus_pkg::sts_t  sub_sts,
  // downstream request (this module is its manager)
  output logic               man_vld,
  output logic               man_wen,
  output tcb_bus_pkg::adr_t  man_adr,
  output tcb_bus_pkg::byt_t  man_byt,
  output tcb_bus_pkg::dat_t  man_wdt,
  input  wire                logic man_rdy,
  // downstream response
  input  wire                logic man_rsp_vld,
  input  tcb_bus_pkg::dat_t  man_rdt,
  input  tcb_bus_pkg::sts_t  man_sts
);

  ////////////////////////////////////////////////////////////
  // held request
  ////////////////////////////////////////////////////////////

  logic              tmp_wen;
  tcb_bus_pkg::adr_t tmp_adr;
  tcb_bus_pkg::byt_t tmp_byt;
  tcb_bus_pkg::dat_t tmp_wdt;

  // capture when accepted upstream but refused downstream
  always_ff @(posedge sub) begin
    if (sub_vld && sub_rdy && !man_rdy) begin
      tmp_wen <= sub_wen;
      tmp_adr <= sub_adr;
      tmp_byt <= sub_byt;
      tmp_wdt <= sub_wdt;
    end
  end

  // pass through while ready, replay the held copy while stalled
  assign man_vld = sub_rdy ? sub_vld : 1'b1;
  assign man_wen = sub_rdy ? sub_wen : tmp_wen;
  assign man_adr = sub_rdy ? sub_adr : tmp_adr;
  assign man_byt = sub_rdy ? sub_byt : tmp_byt;
  assign man_wdt = sub_rdy ? sub_wdt : tmp_wdt;

  ////////////////////////////////////////////////////////////
  // registered ready
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sub) begin
    if (reset) begin
      sub_rdy <= 1'b1;
    end else if (sub_rdy) begin
      // drop after a transfer that downstream did not take
      sub_rdy <= !(sub_vld && !man_rdy);
    end else begin
      // held request goes out on this edge
      sub_rdy <= man_rdy;
    end
  end

  // response needs no buffering, no back-pressure on it
  assign sub_rsp_vld = man_rsp_vld;
  assign sub_rdt     = man_rdt;
  assign sub_sts     = man_sts;

endmodule

`default_nettype wire

// ==== rtl/tcb_status_regs.sv ====
/*
  TCB status register bank
  identity, scratch and wait-state registers, always ready
*/

`default_nettype none
`timescale 1ns/100ps

module tcb_status_regs (
  input  wire                logic sub,
  input  wire                logic reset,
  input  wire                logic vld,
  input  wire                logic wen,
  input  tcb_bus_pkg::adr_t  adr,
  input  tcb_bus_pkg::byt_t  byt,
  input  tcb_bus_pkg::dat_t  wdt,
  output logic               rdy,
  output logic               rsp_vld,
  output tcb_bus_pkg::dat_t  rdt,
  output tcb_map_pkg::wait_t wait_cycles
);

  // no wait states here
  assign rdy = 1'b1;

  ////////////////////////////////////////////////////////////
  // offset decode
  ////////////////////////////////////////////////////////////

  tcb_map_pkg::ofs_t ofs;
  logic              trn;
  logic              sel_scratch;
  logic              sel_wait;

  // only the low address bits matter inside the window
  assign ofs         = adr[3:0];
  assign trn         = vld && rdy;
  assign sel_scratch = (ofs == tcb_map_pkg::reg_scratch_ofs);
  assign sel_wait    = (ofs == tcb_map_pkg::reg_wait_ofs);

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  tcb_bus_pkg::dat_t scratch;
  tcb_bus_pkg::dat_t wait_word;

  // wait value sits in lane 0, upper bits read as zero
  assign wait_word = tcb_bus_pkg::dat_t'(wait_cycles);

  // ID is read only, writes to it and unknown offsets are dropped
  always_ff @(posedge sub) begin
    if (reset) begin
      scratch     <= '0;
      wait_cycles <= '0;
    end else if (trn && wen) begin
      if (sel_scratch) scratch <= tcb_bus_pkg::byte_merge(scratch, wdt, byt);
      if (sel_wait && byt[0]) wait_cycles <= wdt[3:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // read response
  ////////////////////////////////////////////////////////////

  // writes answer with zero data
  always_ff @(posedge sub) begin
    if (trn) begin
      if (wen) begin
        rdt <= '0;
      end else begin
        case (ofs)
          tcb_map_pkg::reg_id_ofs:      rdt <= tcb_map_pkg::id_value;
          tcb_map_pkg::reg_scratch_ofs: rdt <= scratch;
          tcb_map_pkg::reg_wait_ofs:    rdt <= wait_word;
          default:                      rdt <= '0;
        endcase
      end
    end
  end

  always_ff @(posedge sub) begin
    if (reset) rsp_vld <= 1'b0;
    else       rsp_vld <= trn;
  end

endmodule

`default_nettype wire

// ==== rtl/tcb_subsystem.sv ====
/*
  TCB subsystem top level
  register slice, address decoder, word memory and register bank
*/

`default_nettype none
`timescale 1ns/100ps

module tcb_subsystem #(
  parameter int unsigned mem_words = 256
) (
  input  wire                logic sub,
  input  wire                logic reset,
  input  wire                logic vld,
  input  wire                logic wen,
  input  tcb_bus_pkg::adr_t  adr,
  input  tcb_bus_pkg::byt_t  byt,
  input  tcb_bus_pkg::dat_t  wdt,
  output logic               rdy,
  output logic               rsp_vld,
  output tcb_bus_pkg::dat_t  rdt,
  output tcb_bus_pkg::sts_t  sts
);

  ////////////////////////////////////////////////////////////
  // internal links
  ////////////////////////////////////////////////////////////

  // slice to decoder
  logic               man_vld, man_wen, man_rdy, man_rsp_vld;
  tcb_bus_pkg::adr_t  man_adr;
  tcb_bus_pkg::byt_t  man_byt;
  tcb_bus_pkg::dat_t  man_wdt, man_rdt;
  tcb_bus_pkg::sts_t  man_sts;
  // decoder to memory
  logic               mem_vld, mem_wen, mem_rdy, mem_rsp_vld;
  tcb_bus_pkg::adr_t  mem_adr;
  tcb_bus_pkg::byt_t  mem_byt;
  tcb_bus_pkg::dat_t  mem_wdt, mem_rdt;
  // decoder to register bank
  logic               regs_vld, regs_wen, regs_rdy, regs_rsp_vld;
  tcb_bus_pkg::adr_t  regs_adr;
  tcb_bus_pkg::byt_t  regs_byt;
  tcb_bus_pkg::dat_t  regs_wdt, regs_rdt;
  // register bank to memory
  tcb_map_pkg::wait_t wait_cycles;

  tcb_register_backpressure slice (
    .sub, .reset,
    .sub_vld (vld), .sub_wen (wen), .sub_adr (adr), .sub_byt (byt), .sub_wdt (wdt),
    .sub_rdy (rdy), .sub_rsp_vld (rsp_vld), .sub_rdt (rdt), .sub_sts (sts),
    .man_vld, .man_wen, .man_adr, .man_byt, .man_wdt,
    .man_rdy, .man_rsp_vld, .man_rdt, .man_sts
  );

  tcb_decoder #(.mem_words (mem_words)) decoder (
    .sub, .reset,
    .vld (man_vld), .wen (man_wen), .adr (man_adr), .byt (man_byt), .wdt (man_wdt),
    .rdy (man_rdy), .rsp_vld (man_rsp_vld), .rdt (man_rdt), .sts (man_sts),
    .mem_vld, .mem_wen, .mem_adr, .mem_byt, .mem_wdt, .mem_rdy, .mem_rsp_vld, .mem_rdt,
    .regs_vld, .regs_wen, .regs_adr, .regs_byt, .regs_wdt,
    .regs_rdy, .regs_rsp_vld, .regs_rdt
  );

  tcb_memory #(.mem_words (mem_words)) memory (
    .sub, .reset,
    .vld (mem_vld), .wen (mem_wen), .adr (mem_adr), .byt (mem_byt), .wdt (mem_wdt),
    .wait_cycles,
    .rdy (mem_rdy), .rsp_vld (mem_rsp_vld), .rdt (mem_rdt)
  );

  tcb_status_regs regs (
    .sub, .reset,
    .vld (regs_vld), .wen (regs_wen), .adr (regs_adr), .byt (regs_byt), .wdt (regs_wdt),
    .rdy (regs_rdy), .rsp_vld (regs_rsp_vld), .rdt (regs_rdt),
    .wait_cycles
  );

endmodule

`default_nettype wire

// ==== testbench/tcb_tb_table.svh ====
/*
  stimulus and expected-value table for the TCB subsystem testbench
  one row per access in the order applied
  writes expect rdt zero
*/

`ifndef TCB_TB_TABLE_SVH
`define TCB_TB_TABLE_SVH

localparam int num_rows = 34;

// row fields are name wen adr byt wdt and the expected rdt and sts
localparam row_t table_rows [num_rows] = '{
  // identity and reset values of the register bank
  '{"id_rd",       1'b0, 16'h1000, 4'b1111, 32'h0000_0000, 32'h7CB0_0001, 1'b0},
  '{"scr_rd0",     1'b0, 16'h1004, 4'b1111, 32'h0000_0000, 32'h0000_0000, 1'b0},
  '{"wait_rd0",    1'b0, 16'h1008, 4'b1111, 32'h0000_0000, 32'h0000_0000, 1'b0},
  // scratch full word then partial lanes
  '{"scr_wr",      1'b1, 16'h1004, 4'b1111, 32'h1234_5678, 32'h0000_0000, 1'b0},
  '{"scr_rd",      1'b0, 16'h1004, 4'b1111, 32'h0000_0000, 32'h1234_5678, 1'b0},
  '{"scr_wr_b1",   1'b1, 16'h1004, 4'b0010, 32'hAABB_CCDD, 32'h0000_0000, 1'b0},
  '{"scr_rd_b1",   1'b0, 16'h1004, 4'b1111, 32'h0000_0000, 32'h1234_CC78, 1'b0},
  '{"scr_wr_hi",   1'b1, 16'h1004, 4'b1100, 32'h9988_7766, 32'h0000_0000, 1'b0},
  '{"scr_rd_hi",   1'b0, 16'h1004, 4'b1111, 32'h0000_0000, 32'h9988_CC78, 1'b0},
  // ID ignores writes
  '{"id_wr",       1'b1, 16'h1000, 4'b1111, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0},
  '{"id_rd2",      1'b0, 16'h1000, 4'b1111, 32'h0000_0000, 32'h7CB0_0001, 1'b0},
  // memory words up to the top of 256 words
  '{"mem_wr0",     1'b1, 16'h0000, 4'b1111, 32'hDEAD_BEEF, 32'h0000_0000, 1'b0},
  '{"mem_wr1",     1'b1, 16'h0004, 4'b1111, 32'h0123_4567, 32'h0000_0000, 1'b0},
  '{"mem_wr_top",  1'b1, 16'h03FC, 4'b1111, 32'hCAFE_F00D, 32'h0000_0000, 1'b0},
  '{"mem_rd0",     1'b0, 16'h0000, 4'b1111, 32'h0000_0000, 32'hDEAD_BEEF, 1'b0},
  '{"mem_rd1",     1'b0, 16'h0004, 4'b1111, 32'h0000_0000, 32'h0123_4567, 1'b0},
  // lanes 0 and 2 merged into the old word
  '{"mem_wr0_b",   1'b1, 16'h0000, 4'b0101, 32'h1122_3344, 32'h0000_0000, 1'b0},
  '{"mem_rd0_b",   1'b0, 16'h0000, 4'b1111, 32'h0000_0000, 32'hDE22_BE44, 1'b0},
  '{"mem_rd_top",  1'b0, 16'h03FC, 4'b1111, 32'h0000_0000, 32'hCAFE_F00D, 1'b0},
  // unmapped addresses then a normal access
  '{"err_rd",      1'b0, 16'h2000, 4'b1111, 32'h0000_0000, 32'h0000_0000, 1'b1},
  '{"err_wr",      1'b1, 16'h1010, 4'b1111, 32'h5555_5555, 32'h0000_0000, 1'b1},
  '{"after_err",   1'b0, 16'h1004, 4'b1111, 32'h0000_0000, 32'h9988_CC78, 1'b0},
  // three wait states stall memory behind the slice
  // wait keeps only the low 4 bits of the written word
  '{"wait_wr",     1'b1, 16'h1008, 4'b1111, 32'hFFFF_FFF3, 32'h0000_0000, 1'b0},
  '{"wait_rd",     1'b0, 16'h1008, 4'b1111, 32'h0000_0000, 32'h0000_0003, 1'b0},
  '{"ws_wr2",      1'b1, 16'h0008, 4'b1111, 32'hA5A5_A5A5, 32'h0000_0000, 1'b0},
  '{"ws_wr3",      1'b1, 16'h000C, 4'b1111, 32'h5A5A_5A5A, 32'h0000_0000, 1'b0},
  '{"ws_rd0",      1'b0, 16'h0000, 4'b1111, 32'h0000_0000, 32'hDE22_BE44, 1'b0},
  '{"ws_rd2",      1'b0, 16'h0008, 4'b1111, 32'h0000_0000, 32'hA5A5_A5A5, 1'b0},
  '{"ws_rd3",      1'b0, 16'h000C, 4'b1111, 32'h0000_0000, 32'h5A5A_5A5A, 1'b0},
  '{"ws_wr1_b",    1'b1, 16'h0004, 4'b1000, 32'h7700_0000, 32'h0000_0000, 1'b0},
  '{"ws_rd1",      1'b0, 16'h0004, 4'b1111, 32'h0000_0000, 32'h7723_4567, 1'b0},
  // wait states back to zero
  '{"wait_clr",    1'b1, 16'h1008, 4'b0001, 32'h0000_0000, 32'h0000_0000, 1'b0},
  '{"wait_rd_clr", 1'b0, 16'h1008, 4'b1111, 32'h0000_0000, 32'h0000_0000, 1'b0},
  '{"mem_rd2",     1'b0, 16'h0008, 4'b1111, 32'h0000_0000, 32'hA5A5_A5A5, 1'b0}
};

`endif

// ==== testbench/tcb_subsystem_tb.sv ====
/*
  testbench for the TCB subsystem
  clock, reset, table-driven request driver, in-order response checker,
  value check task and watchdog
*/

`default_nettype none
`timescale 1ns/100ps

module tcb_subsystem_tb;

  // one access of the table
  typedef struct packed {
    logic [8*16-1:0]   name;
    logic              wen;
    tcb_bus_pkg::adr_t adr;
    tcb_bus_pkg::byt_t byt;
    tcb_bus_pkg::dat_t wdt;
    tcb_bus_pkg::dat_t rdt;
    tcb_bus_pkg::sts_t sts;
  } row_t;

  `include "tcb_tb_table.svh"

  logic              sub;
  logic              reset;
  logic              vld;
  logic              wen;
  tcb_bus_pkg::adr_t adr;
  tcb_bus_pkg::byt_t byt;
  tcb_bus_pkg::dat_t wdt;
  logic              rdy;
  logic              rsp_vld;
  tcb_bus_pkg::dat_t rdt;
  tcb_bus_pkg::sts_t sts;

  // row indices accepted at the top, oldest first
  int pending_q [$];

  tcb_subsystem #(.mem_words (256)) DUT (
    .sub, .reset, .vld, .wen, .adr, .byt, .wdt,
    .rdy, .rsp_vld, .rdt, .sts
  );

  ////////////////////////////////////////////////////////////
  // clock and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    sub = 1'b0;
    forever #50 sub = ~sub;
  end

  // worst row is a few idle cycles plus wait states
  initial begin
    repeat (num_rows * 25 + 100) @(posedge sub);
    $display("timeout: run did not end within %0d clock periods", num_rows * 25 + 100);
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0s: expected 0x%08h, actual 0x%08h", what, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic string row_label(input int idx, input string field);
    return $sformatf("%0s %0s", table_rows[idx].name, field);
  endfunction

  // present one row at edge plus 1 ns, hold until rdy seen at an edge
  task automatic drive_row(input int idx);
    logic taken;
    vld   = 1'b1;
    wen   = table_rows[idx].wen;
    adr   = table_rows[idx].adr;
    byt   = table_rows[idx].byt;
    wdt   = table_rows[idx].wdt;
    taken = 1'b0;
    while (!taken) begin
      // rdy is registered, stable mid cycle
      @(negedge sub);
      taken = rdy;
      @(posedge sub);
    end
    pending_q.push_back(idx);
    #1;
    vld = 1'b0;
    wen = 1'b0;
    adr = '0;
    byt = '0;
    wdt = '0;
  endtask

  ////////////////////////////////////////////////////////////
  // response checker
  ////////////////////////////////////////////////////////////

  initial begin
    int idx;
    forever begin
      @(negedge sub);
      if (!reset && rsp_vld) begin
        if (pending_q.size() == 0) begin
          $display("unexpected response with no access outstanding, rdt 0x%08h", rdt);
          $display("CHECKS FAILED");
          $fatal(1, "unexpected response");
        end else begin
          idx = pending_q.pop_front();
          check_value(row_label(idx, "rdt"), table_rows[idx].rdt, rdt);
          check_value(row_label(idx, "sts"), 32'(table_rows[idx].sts), 32'(sts));
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned gap;
    int          drain;
    void'($urandom(39));
    reset = 1'b1;
    vld   = 1'b0;
    wen   = 1'b0;
    adr   = '0;
    byt   = '0;
    wdt   = '0;
    repeat (16) @(posedge sub);
    #1 reset = 1'b0;
    // idle bus after reset
    @(negedge sub);
    check_value("reset rdy", 32'h1, 32'(rdy));
    check_value("reset rsp_vld", 32'h0, 32'(rsp_vld));
    @(posedge sub);
    #1;
    for (int i = 0; i < num_rows; i++) begin
      // 0 to 3 idle cycles before each request
      gap = $urandom % 4;
      repeat (gap) begin
        @(posedge sub);
        #1;
      end
      drive_row(i);
    end
    // last responses drain
    drain = 0;
    while (pending_q.size() != 0 && drain < 32) begin
      @(posedge sub);
      drain++;
    end
    repeat (4) @(posedge sub);
    if (pending_q.size() != 0) begin
      $display("missing response: %0d accesses were never answered", pending_q.size());
      $display("CHECKS FAILED");
      $fatal(1, "missing response");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
